// ==== src/quant_pkg.sv ====
// BF16 and INT8 types and field constants; BF16 here has no subnormal support
package quant_pkg;

    // ------------------------------------------------------------------------
    // Vector types
    // ------------------------------------------------------------------------

    // BF16 value: sign [15], exponent [14:7], mantissa [6:0]
    typedef logic [15:0] bf16_t;

    // Biased BF16 exponent field
    typedef logic [7:0] bf16_exp_t;

    // Stored BF16 mantissa, leading one implied
    typedef logic [6:0] bf16_man_t;

    // Two's-complement INT8 result
    typedef logic [7:0] q8_t;

    // ------------------------------------------------------------------------
    // Field constants
    // ------------------------------------------------------------------------

    // Exponent bias, biased 127 means 2^0
    localparam bf16_exp_t bf16_exp_bias = 8'd127;

    // All-ones exponent marks infinity (mantissa zero) or NaN
    localparam bf16_exp_t bf16_exp_max = 8'd255;

endpackage : quant_pkg

// ==== src/math_bf16_mul.sv ====
// Combinational BF16 multiply, RNE only, subnormal inputs and results flush to signed zero
`timescale 1ns/100ps

module math_bf16_mul (
    input  quant_pkg::bf16_t a,
    input  quant_pkg::bf16_t b,
    output quant_pkg::bf16_t product
);

    // Canonical quiet NaN
    localparam quant_pkg::bf16_t QNAN = 16'h7FC0;

    // ------------------------------------------------------------------------
    // Operand fields
    // ------------------------------------------------------------------------
    logic                 sign_a;
    logic                 sign_b;
    logic                 sign_p;
    quant_pkg::bf16_exp_t exp_a;
    quant_pkg::bf16_exp_t exp_b;
    quant_pkg::bf16_man_t man_a;
    quant_pkg::bf16_man_t man_b;
    logic                 zero_a;
    logic                 zero_b;
    logic                 inf_a;
    logic                 inf_b;
    logic                 nan_a;
    logic                 nan_b;

    assign {sign_a, exp_a, man_a} = a;
    assign {sign_b, exp_b, man_b} = b;
    assign sign_p = sign_a ^ sign_b;

    // Exponent zero covers true zero and flushed subnormals
    assign zero_a = (exp_a == 8'd0);
    assign zero_b = (exp_b == 8'd0);
    assign inf_a  = (exp_a == quant_pkg::bf16_exp_max) && (man_a == 7'd0);
    assign inf_b  = (exp_b == quant_pkg::bf16_exp_max) && (man_b == 7'd0);
    assign nan_a  = (exp_a == quant_pkg::bf16_exp_max) && (man_a != 7'd0);
    assign nan_b  = (exp_b == quant_pkg::bf16_exp_max) && (man_b != 7'd0);

    // ------------------------------------------------------------------------
    // Significand product and normalization
    // ------------------------------------------------------------------------
    logic [15:0]        sig_prod;
    logic               norm_hi;
    logic [6:0]         man_pre;
    logic               guard;
    logic               sticky;
    logic               round_up;
    logic [7:0]         man_rnd;
    logic signed [9:0]  exp_sum;
    logic signed [9:0]  exp_fin;

    // 1.m x 1.m lies in [1, 4), so bit 15 or bit 14 holds the leading one
    assign sig_prod = {1'b1, man_a} * {1'b1, man_b};
    assign norm_hi  = sig_prod[15];

    // Product in [2, 4) takes one place of right shift
    assign man_pre = norm_hi ? sig_prod[14:8] : sig_prod[13:7];
    assign guard   = norm_hi ? sig_prod[7] : sig_prod[6];
    assign sticky  = norm_hi ? (|sig_prod[6:0]) : (|sig_prod[5:0]);

    // Round to nearest, ties to even mantissa
    assign round_up = guard & (sticky | man_pre[0]);
    assign man_rnd  = {1'b0, man_pre} + {7'd0, round_up};

    // Ten signed bits hold the whole range of ea + eb - bias + 2
    assign exp_sum = $signed({2'b00, exp_a}) + $signed({2'b00, exp_b})
                   - $signed({2'b00, quant_pkg::bf16_exp_bias})
                   + $signed({9'd0, norm_hi});
    // Rounding carry leaves mantissa zero and bumps the exponent
    assign exp_fin = exp_sum + $signed({9'd0, man_rnd[7]});

    // ------------------------------------------------------------------------
    // Result select, specials first
    // ------------------------------------------------------------------------
    always_comb begin
        product = {sign_p, exp_fin[7:0], man_rnd[6:0]};
        if (nan_a || nan_b || (inf_a && zero_b) || (inf_b && zero_a)) begin
            product = QNAN;
        end else if (inf_a || inf_b) begin
            product = {sign_p, quant_pkg::bf16_exp_max, 7'd0};
        end else if (zero_a || zero_b || (exp_fin <= 10'sd0)) begin
            // Underflow flushes, no subnormal result
            product = {sign_p, 15'd0};
        end else if (exp_fin >= $signed({2'b00, quant_pkg::bf16_exp_max})) begin
            product = {sign_p, quant_pkg::bf16_exp_max, 7'd0};
        end
    end

endmodule : math_bf16_mul

// ==== src/math_bf16_to_int.sv ====
// Combinational BF16 to INT8, RNE, saturates to -128..+127; NaN gives 0, subnormals read as zero
`timescale 1ns/100ps

module math_bf16_to_int (
    input  quant_pkg::bf16_t bf16,
    output quant_pkg::q8_t   int8,
    output logic             overflow,
    output logic             underflow,
    output logic             is_zero
);

    // ------------------------------------------------------------------------
    // Field decode
    // ------------------------------------------------------------------------
    logic                 sign;
    quant_pkg::bf16_exp_t exp;
    quant_pkg::bf16_man_t man;
    logic                 in_zero;
    logic                 in_inf;
    logic                 in_nan;

    assign {sign, exp, man} = bf16;

    assign in_zero = (exp == 8'd0);
    assign in_inf  = (exp == quant_pkg::bf16_exp_max) && (man == 7'd0);
    assign in_nan  = (exp == quant_pkg::bf16_exp_max) && (man != 7'd0);

    // ------------------------------------------------------------------------
    // Fixed-point alignment
    // ------------------------------------------------------------------------
    logic signed [8:0] exp_unb;
    logic              exp_big;
    logic              exp_small;
    logic [2:0]        shift;
    logic [14:0]       man_shifted;

    assign exp_unb = $signed({1'b0, exp}) - $signed({1'b0, quant_pkg::bf16_exp_bias});

    // Above 2^7 can never fit; below 2^0 is handled separately
    assign exp_big   = (exp_unb > 9'sd7);
    assign exp_small = (exp_unb < 9'sd0);
    assign shift     = exp_big ? 3'd7 : (exp_small ? 3'd0 : exp_unb[2:0]);

    // 1.mmmmmmm has 7 fraction bits; after the shift bits [14:7] are the integer
    assign man_shifted = {7'd0, 1'b1, man} << shift;

    // ------------------------------------------------------------------------
    // Rounding and saturation
    // ------------------------------------------------------------------------
    logic [7:0] mag_raw;
    logic       guard;
    logic       rnd;
    logic       sticky;
    logic       round_up;
    logic [8:0] mag_rnd;
    logic       big_pos;
    logic       big_neg;
    logic [7:0] mag_sat;
    quant_pkg::q8_t res_signed;

    assign mag_raw = man_shifted[14:7];
    assign guard   = man_shifted[6];
    assign rnd     = man_shifted[5];
    assign sticky  = |man_shifted[4:0];

    // Ties go to the even integer
    assign round_up = guard & (rnd | sticky | mag_raw[0]);
    assign mag_rnd  = {1'b0, mag_raw} + {8'd0, round_up};

    // Negative side reaches one step further, down to -128
    assign big_pos = ~sign & (exp_big | (mag_rnd > 9'd127));
    assign big_neg =  sign & (exp_big | (mag_rnd > 9'd128));

    assign mag_sat    = big_pos ? 8'd127 : (big_neg ? 8'd128 : mag_rnd[7:0]);
    assign res_signed = sign ? (~mag_sat + 8'd1) : mag_sat;

    // ------------------------------------------------------------------------
    // Special values override the normal path
    // ------------------------------------------------------------------------
    always_comb begin
        int8      = res_signed;
        overflow  = big_pos;
        underflow = big_neg;
        is_zero   = 1'b0;
        if (in_nan) begin
            // NaN maps to 0, flags stay low
            int8      = 8'd0;
            overflow  = 1'b0;
            underflow = 1'b0;
        end else if (in_inf) begin
            int8      = sign ? 8'h80 : 8'h7F;
            overflow  = ~sign;
            underflow = sign;
        end else if (in_zero) begin
            int8      = 8'd0;
            overflow  = 1'b0;
            underflow = 1'b0;
            is_zero   = 1'b1;
        end else if (exp_small) begin
            overflow  = 1'b0;
            underflow = 1'b0;
            // Exponent 126 spans 0.5..0.99; 0.5 ties to even zero
            if ((exp == quant_pkg::bf16_exp_bias - 8'd1) && (man != 7'd0)) begin
                int8 = sign ? 8'hFF : 8'h01;
            end else begin
                int8    = 8'd0;
                is_zero = 1'b1;
            end
        end
    end

endmodule : math_bf16_to_int

// ==== src/quant_stat_counters.sv ====
// Quantization event counters, hold at all-ones, clear wins over increment; CNT_W of 4 or more
`timescale 1ns/100ps

module quant_stat_counters #(
    parameter int CNT_W = 16
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             clear,
    input  logic             valid,
    input  logic             inc_overflow,
    input  logic             inc_underflow,
    input  logic             inc_zero,
    output logic [CNT_W-1:0] cnt_overflow,
    output logic [CNT_W-1:0] cnt_underflow,
    output logic [CNT_W-1:0] cnt_zero
);

    // Increment that sticks at the top value
    function automatic logic [CNT_W-1:0] sat_inc(input logic [CNT_W-1:0] val);
        sat_inc = (&val) ? val : val + 1'b1;
    endfunction

    // Flags count only on a valid result
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            cnt_overflow  <= '0;
            cnt_underflow <= '0;
            cnt_zero      <= '0;
        end else if (valid) begin
            if (inc_overflow) begin
                cnt_overflow <= sat_inc(cnt_overflow);
            end
            if (inc_underflow) begin
                cnt_underflow <= sat_inc(cnt_underflow);
            end
            if (inc_zero) begin
                cnt_zero <= sat_inc(cnt_zero);
            end
        end
    end

endmodule : quant_stat_counters

// ==== src/bf16_quantizer.sv ====
// BF16 to INT8 quantizer, fixed 2-cycle latency, no back-pressure; outputs valid one cycle only
`timescale 1ns/100ps

module bf16_quantizer #(
    parameter int CNT_W = 16
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  logic             stats_clear,
    input  quant_pkg::bf16_t act,
    input  quant_pkg::bf16_t scale,
    output logic             out_valid,
    output quant_pkg::q8_t   int8,
    output logic             overflow,
    output logic             underflow,
    output logic             is_zero,
    output logic [CNT_W-1:0] cnt_overflow,
    output logic [CNT_W-1:0] cnt_underflow,
    output logic [CNT_W-1:0] cnt_zero
);

    // ------------------------------------------------------------------------
    // Stage 1: scale the activation
    // ------------------------------------------------------------------------
    quant_pkg::bf16_t prod_comb;
    quant_pkg::bf16_t prod_s1;
    logic             valid_s1;

    math_bf16_mul i_mul (
        .a       (act),
        .b       (scale),
        .product (prod_comb)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_s1 <= 1'b0;
        end else begin
            valid_s1 <= in_valid;
        end
    end

    // Product only moves on a valid input
    always_ff @(posedge clk) begin
        if (in_valid) begin
            prod_s1 <= prod_comb;
        end
    end

    // ------------------------------------------------------------------------
    // Stage 2: convert and register the outputs
    // ------------------------------------------------------------------------
    quant_pkg::q8_t conv_int8;
    logic           conv_ovf;
    logic           conv_unf;
    logic           conv_zero;

    math_bf16_to_int i_to_int (
        .bf16      (prod_s1),
        .int8      (conv_int8),
        .overflow  (conv_ovf),
        .underflow (conv_unf),
        .is_zero   (conv_zero)
    );

    // Result fields hold between items and read zero after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            int8      <= '0;
            overflow  <= 1'b0;
            underflow <= 1'b0;
            is_zero   <= 1'b0;
        end else begin
            out_valid <= valid_s1;
            if (valid_s1) begin
                int8      <= conv_int8;
                overflow  <= conv_ovf;
                underflow <= conv_unf;
                is_zero   <= conv_zero;
            end
        end
    end

    // Counters see the registered flags, one cycle behind out_valid
    quant_stat_counters #(
        .CNT_W (CNT_W)
    ) i_stats (
        .clk           (clk),
        .rst           (rst),
        .clear         (stats_clear),
        .valid         (out_valid),
        .inc_overflow  (overflow),
        .inc_underflow (underflow),
        .inc_zero      (is_zero),
        .cnt_overflow  (cnt_overflow),
        .cnt_underflow (cnt_underflow),
        .cnt_zero      (cnt_zero)
    );

endmodule : bf16_quantizer

// ==== tb/tb_bf16_quantizer.sv ====
// Run from the project root so tb/quant_tests.txt is found; counters checked at CNT_W 16 only
`timescale 1ns/100ps

module tb_bf16_quantizer;

    localparam int    CNT_W     = 16;
    localparam string TEST_FILE = "tb/quant_tests.txt";

    logic             clk;
    logic             rst;
    logic             in_valid;
    logic             stats_clear;
    quant_pkg::bf16_t act;
    quant_pkg::bf16_t scale;
    logic             out_valid;
    quant_pkg::q8_t   int8;
    logic             overflow;
    logic             underflow;
    logic             is_zero;
    logic [CNT_W-1:0] cnt_overflow;
    logic [CNT_W-1:0] cnt_underflow;
    logic [CNT_W-1:0] cnt_zero;

    // Vector table, flags packed as {overflow, underflow, is_zero}
    string            vec_name[$];
    quant_pkg::bf16_t vec_act[$];
    quant_pkg::bf16_t vec_scale[$];
    quant_pkg::q8_t   vec_int8[$];
    logic [2:0]       vec_flags[$];

    // Results in flight: vector index and issue cycle
    int pend_idx[$];
    int pend_cycle[$];

    int cycle = 0;
    int limit_cycles = 0;
    int err_count = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int sum_ovf = 0;
    int sum_unf = 0;
    int sum_zero = 0;

    bf16_quantizer #(
        .CNT_W (CNT_W)
    ) i_bf16_quantizer (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .stats_clear   (stats_clear),
        .act           (act),
        .scale         (scale),
        .out_valid     (out_valid),
        .int8          (int8),
        .overflow      (overflow),
        .underflow     (underflow),
        .is_zero       (is_zero),
        .cnt_overflow  (cnt_overflow),
        .cnt_underflow (cnt_underflow),
        .cnt_zero      (cnt_zero)
    );

    // ------------------------------------------------------------------------
    // Clock, cycle count and watchdog
    // ------------------------------------------------------------------------
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Limit is set once the vectors are loaded
    initial begin
        wait (limit_cycles > 0);
        wait (cycle >= limit_cycles);
        $display("Timeout after %0d cycles with %0d results pending", cycle, pend_idx.size());
        $display("STATUS: FAIL");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    task automatic load_vectors();
        int          fd;
        int          n;
        int          o;
        int          u;
        int          z;
        string       line;
        string       name;
        logic [15:0] a;
        logic [15:0] s;
        logic [7:0]  q;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open vector file %s", TEST_FILE);
            err_count++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                // Skip comments and blank lines
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %h %h %h %d %d %d", name, a, s, q, o, u, z);
                    if (n != 7) begin
                        $display("Malformed vector line: %s", line);
                        err_count++;
                    end else begin
                        vec_name.push_back(name);
                        vec_act.push_back(a);
                        vec_scale.push_back(s);
                        vec_int8.push_back(q);
                        vec_flags.push_back({o != 0, u != 0, z != 0});
                        sum_ovf  += (o != 0);
                        sum_unf  += (u != 0);
                        sum_zero += (z != 0);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic report_test(input string name, input logic ok);
        tests_run++;
        if (ok) begin
            $display("[pass] %s", name);
        end else begin
            tests_failed++;
            $display("[fail] %s", name);
        end
    endtask

    // One-cycle strobe, entered 1 ns after the edge
    task automatic drive_vector(input int idx);
        in_valid = 1'b1;
        act      = vec_act[idx];
        scale    = vec_scale[idx];
        pend_idx.push_back(idx);
        pend_cycle.push_back(cycle);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    // Wait for outstanding results, then let the counters settle
    task automatic wait_drain();
        int waited;
        waited = 0;
        while (pend_idx.size() > 0 && waited < 10) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (pend_idx.size() > 0) begin
            $display("%0d result(s) never arrived", pend_idx.size());
            err_count++;
            pend_idx.delete();
            pend_cycle.delete();
        end
        repeat (2) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_counters(input string tag, input int e_o, input int e_u, input int e_z);
        logic ok;
        ok = 1'b1;
        if (cnt_overflow !== CNT_W'(e_o)) begin
            $display("MISMATCH %s cnt_overflow expected %0d actual %0d", tag, e_o, cnt_overflow);
            ok = 1'b0;
        end
        if (cnt_underflow !== CNT_W'(e_u)) begin
            $display("MISMATCH %s cnt_underflow expected %0d actual %0d", tag, e_u, cnt_underflow);
            ok = 1'b0;
        end
        if (cnt_zero !== CNT_W'(e_z)) begin
            $display("MISMATCH %s cnt_zero expected %0d actual %0d", tag, e_z, cnt_zero);
            ok = 1'b0;
        end
        report_test(tag, ok);
    endtask

    // Reset leaves out_valid low, the result fields zero and the counters zero
    task automatic check_reset_state();
        logic ok;
        ok = 1'b1;
        if (out_valid !== 1'b0) begin
            $display("MISMATCH reset_state out_valid expected 0 actual %b", out_valid);
            ok = 1'b0;
        end
        if (int8 !== 8'h00) begin
            $display("MISMATCH reset_state int8 expected 00 actual %02h", int8);
            ok = 1'b0;
        end
        if ({overflow, underflow, is_zero} !== 3'b000) begin
            $display("MISMATCH reset_state flags ovf/unf/zero expected 000 actual %03b",
                     {overflow, underflow, is_zero});
            ok = 1'b0;
        end
        report_test("reset_state", ok);
        check_counters("counters_reset", 0, 0, 0);
    endtask

    // ------------------------------------------------------------------------
    // Output checker, sampled mid-cycle where outputs are stable
    // ------------------------------------------------------------------------
    always @(negedge clk) begin : check_outputs
        int   idx;
        int   issued;
        logic ok;
        if (!rst && out_valid) begin
            if (pend_idx.size() == 0) begin
                $display("out_valid seen at cycle %0d with no result pending", cycle);
                err_count++;
            end else begin
                idx    = pend_idx.pop_front();
                issued = pend_cycle.pop_front();
                ok     = 1'b1;
                if (int8 !== vec_int8[idx]) begin
                    $display("MISMATCH %s int8 expected %02h actual %02h",
                             vec_name[idx], vec_int8[idx], int8);
                    ok = 1'b0;
                end
                if ({overflow, underflow, is_zero} !== vec_flags[idx]) begin
                    $display("MISMATCH %s flags ovf/unf/zero expected %03b actual %03b",
                             vec_name[idx], vec_flags[idx], {overflow, underflow, is_zero});
                    ok = 1'b0;
                end
                // Latency is fixed at two clocks
                if (cycle - issued != 2) begin
                    $display("MISMATCH %s latency expected 2 actual %0d",
                             vec_name[idx], cycle - issued);
                    ok = 1'b0;
                end
                report_test(vec_name[idx], ok);
            end
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    initial begin : main
        int gap;
        void'($urandom(66988));
        rst         = 1'b1;
        in_valid    = 1'b0;
        stats_clear = 1'b0;
        act         = '0;
        scale       = '0;
        load_vectors();
        if (vec_name.size() == 0) begin
            $display("No test vectors loaded");
            err_count++;
        end
        // Two passes over the table
        limit_cycles = 3 * 2 * vec_name.size() + 50;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        check_reset_state();
        // Pass 0 with random idle gaps, pass 1 back to back
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < vec_name.size(); i++) begin
                drive_vector(i);
                gap = (pass == 0) ? int'($urandom % 3) : 0;
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                end
            end
            wait_drain();
            check_counters($sformatf("counters_pass%0d", pass), sum_ovf, sum_unf, sum_zero);
            stats_clear = 1'b1;
            @(posedge clk);
            #1;
            stats_clear = 1'b0;
            check_counters($sformatf("counters_clear%0d", pass), 0, 0, 0);
        end
        $display("Tests run %0d, failed %0d, other errors %0d", tests_run, tests_failed, err_count);
        if (tests_failed == 0 && err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule : tb_bf16_quantizer

// ==== bf16_quantizer.f ====
src/quant_pkg.sv
src/math_bf16_mul.sv
src/math_bf16_to_int.sv
src/quant_stat_counters.sv
src/bf16_quantizer.sv
tb/tb_bf16_quantizer.sv

// ==== Makefile ====
# Verilator build for the BF16 to INT8 quantizer

TOOL       = verilator
TOP        = tb_bf16_quantizer
FILELIST   = bf16_quantizer.f
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing -Wno-fatal -Mdir obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The grep sets the exit status, so a failing run fails the target
sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb/quant_tests.txt ====
# Columns: name act scale int8 overflow underflow is_zero
# act, scale and int8 in hex; the three flags as 0 or 1
one_x1 3F80 3F80 01 0 0 0
p127_x1 42FE 3F80 7F 0 0 0
m128_x1 C300 3F80 80 0 0 0
p2p5_even 4020 3F80 02 0 0 0
p3p5_even 4060 3F80 04 0 0 0
m2p5_even C020 3F80 FE 0 0 0
p0p75_x4 3F40 4080 03 0 0 0
p3_x0p5_tie 4040 3F00 02 0 0 0
p1p5_sq 3FC0 3FC0 02 0 0 0
p127p5_sat 40A0 41CC 7F 1 0 0
m127p5_tie C2FF 3F80 80 0 0 0
p128_sat 4300 3F80 7F 1 0 0
m200_sat C348 3F80 80 0 1 0
pinf 7F80 3F80 7F 1 0 0
minf FF80 3F80 80 0 1 0
big_x_big 7F00 7F00 7F 1 0 0
mbig_x_big FF00 7F00 80 0 1 0
nan 7FC0 3F80 00 0 0 0
inf_x_zero 7F80 0000 00 0 0 0
half 3F00 3F80 00 0 0 1
subnormal 0040 3F80 00 0 0 1
p0p75 3F40 3F80 01 0 0 0
m0p75 BF40 3F80 FF 0 0 0
quarter 3E80 3F80 00 0 0 1
neg_zero 8000 3F80 00 0 0 1
mul_underflow 0080 3F00 00 0 0 1
